//--- verilog/demosaic_cfg.svh
`ifndef DEMOSAIC_CFG_SVH
`define DEMOSAIC_CFG_SVH

// ====================
// Pixel format
// ====================

`define DM_RAW_PX_WIDTH  10   // Raw sensor pixel width in bits.

// ====================
// Line memories
// ====================

`define DM_MAX_LINE_SIZE 64   // Longest supported line and depth of each line memory.

`endif

//--- verilog/demosaic_pkg.sv
`default_nettype none
`include "demosaic_cfg.svh"

package demosaic_pkg;

typedef logic [`DM_RAW_PX_WIDTH - 1:0] raw_px_t;

// Red sits in the most significant bits.
typedef struct packed {
  raw_px_t r;
  raw_px_t g;
  raw_px_t b;
} rgb_px_t;

// Indexed [row][col] with row 0 the oldest line and col 0 the leftmost pixel.
typedef raw_px_t [2:0][2:0] win3_t;

// The colour at a pixel site is encoded as {odd line, odd pixel}.
typedef enum logic [1:0] {
  PH_R  = 2'b00,
  PH_GR = 2'b01,
  PH_GB = 2'b10,
  PH_B  = 2'b11
} bayer_phase_e;

endpackage

`default_nettype wire

//--- verilog/video_stream_if.sv
`default_nettype none
`include "demosaic_cfg.svh"

interface video_stream_if #(
  parameter int WIDTH = `DM_RAW_PX_WIDTH
);

logic [WIDTH - 1:0] tdata;
logic               tvalid;
logic               tready;
logic               tlast;   // Last pixel of a line.
logic               tuser;   // First pixel of a frame.

modport master (
  output tdata,
  output tvalid,
  output tlast,
  output tuser,
  input  tready
);

modport slave (
  input  tdata,
  input  tvalid,
  input  tlast,
  input  tuser,
  output tready
);

endinterface

`default_nettype wire

//--- verilog/line_buffer.sv
`default_nettype none
`include "demosaic_cfg.svh"

module line_buffer #(
  parameter int WIDTH = `DM_RAW_PX_WIDTH,
  parameter int DEPTH = `DM_MAX_LINE_SIZE
)(
  input  wire                clk_i,
  input  wire                rst_i,
  input  wire                shift_i,
  input  wire  [WIDTH - 1:0] data_i,
  output logic [WIDTH - 1:0] data_o,
  input  wire                line_end_i
);

localparam int ADDR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

logic [WIDTH - 1:0]  mem [DEPTH];
logic [ADDR_W - 1:0] col;

// ====================
// Storage
// ====================

// The old pixel is visible before the write at the same edge replaces it.
assign data_o = mem[col];

always_ff @(posedge clk_i)
  if (shift_i)
    mem[col] <= data_i;

// ====================
// Column counter
// ====================

always_ff @(posedge clk_i, posedge rst_i)
  if (rst_i)
    col <= '0;
  else
    if (shift_i)
      if (line_end_i || (col == ADDR_W'(DEPTH - 1)))
        col <= '0;                                   // Delay follows the actual line length.
      else
        col <= col + ADDR_W'(1);

endmodule

`default_nettype wire

//--- verilog/window_buf.sv
`default_nettype none
`include "demosaic_cfg.svh"

module window_buf #(
  parameter int PX_WIDTH      = `DM_RAW_PX_WIDTH,
  parameter int MAX_LINE_SIZE = `DM_MAX_LINE_SIZE
)(
  input wire             clk_i,
  input wire             rst_i,
  video_stream_if.slave  video_i,
  video_stream_if.master window_o
);

localparam int COL_W = (MAX_LINE_SIZE > 1) ? $clog2(MAX_LINE_SIZE) : 1;

typedef enum logic [1:0] {
  IDLE,
  FILL,
  RUN,
  FLUSH
} state_e;

state_e                          state;
logic                            second_line;
logic                            sof_pending;
logic [COL_W - 1:0]              col_cnt;
logic                            slot_free;
logic                            px_acc;
logic [PX_WIDTH - 1:0]           px_mid;
logic [PX_WIDTH - 1:0]           px_top;
logic [2:0][PX_WIDTH - 1:0]      new_col;
logic [2:0][1:0][PX_WIDTH - 1:0] sh;
logic [2:0][2:0][PX_WIDTH - 1:0] run_win;
logic [2:0][2:0][PX_WIDTH - 1:0] flush_win;

// ====================
// Handshake
// ====================

assign slot_free      = !window_o.tvalid || window_o.tready;
assign video_i.tready = slot_free && (state != FLUSH);   // Input stalls during the edge flush.
assign px_acc         = video_i.tvalid && video_i.tready;

// ====================
// Line memories
// ====================

line_buffer #(
  .WIDTH      ( PX_WIDTH      ),
  .DEPTH      ( MAX_LINE_SIZE )
) lb_mid_inst (
  .clk_i      ( clk_i         ),
  .rst_i      ( rst_i         ),
  .shift_i    ( px_acc        ),
  .data_i     ( video_i.tdata ),
  .data_o     ( px_mid        ),
  .line_end_i ( video_i.tlast )
);

line_buffer #(
  .WIDTH      ( PX_WIDTH      ),
  .DEPTH      ( MAX_LINE_SIZE )
) lb_top_inst (
  .clk_i      ( clk_i         ),
  .rst_i      ( rst_i         ),
  .shift_i    ( px_acc        ),
  .data_i     ( px_mid        ),
  .data_o     ( px_top        ),
  .line_end_i ( video_i.tlast )
);

// Row 2 is the incoming line, row 0 the oldest one.
assign new_col = {video_i.tdata, px_mid, px_top};

// ====================
// Window assembly
// ====================

// The incoming column acts as the third column of each shift register.
always_comb
  for (int r = 0; r < 3; r++)
    begin
      run_win[r][0]   = (col_cnt == COL_W'(1)) ? sh[r][1] : sh[r][0];   // Left edge copy.
      run_win[r][1]   = sh[r][1];
      run_win[r][2]   = new_col[r];
      flush_win[r][0] = sh[r][0];
      flush_win[r][1] = sh[r][1];
      flush_win[r][2] = sh[r][1];                                          // Right edge copy.
    end

always_ff @(posedge clk_i)
  if (state == FLUSH)
    begin
      if (slot_free)
        window_o.tdata <= flush_win;
    end
  else
    if (px_acc)
      begin
        window_o.tdata <= run_win;
        for (int r = 0; r < 3; r++)
          begin
            sh[r][0] <= sh[r][1];
            sh[r][1] <= new_col[r];
          end
      end

// ====================
// Control FSM
// ====================

always_ff @(posedge clk_i, posedge rst_i)
  if (rst_i)
    begin
      state           <= IDLE;
      second_line     <= 1'b0;
      sof_pending     <= 1'b0;
      col_cnt         <= '0;
      window_o.tvalid <= 1'b0;
      window_o.tlast  <= 1'b0;
      window_o.tuser  <= 1'b0;
    end
  else
    begin
      if (window_o.tready)
        window_o.tvalid <= 1'b0;
      if (px_acc)
        col_cnt <= video_i.tlast ? '0 : col_cnt + COL_W'(1);
      case (state)
        IDLE:
          if (px_acc && video_i.tuser)
            begin
              state       <= FILL;
              second_line <= 1'b0;
            end
        FILL:
          if (px_acc)
            if (video_i.tuser)
              second_line <= 1'b0;
            else
              if (video_i.tlast)
                if (second_line)
                  begin
                    state       <= RUN;        // Two lines are now buffered.
                    sof_pending <= 1'b1;
                  end
                else
                  second_line <= 1'b1;
        RUN:
          if (px_acc)
            if (video_i.tuser)
              begin
                state       <= FILL;           // A new frame restarts the fill.
                second_line <= 1'b0;
                sof_pending <= 1'b0;
              end
            else
              if (col_cnt != '0)
                begin
                  window_o.tvalid <= 1'b1;
                  window_o.tlast  <= 1'b0;
                  window_o.tuser  <= sof_pending;
                  sof_pending     <= 1'b0;
                  if (video_i.tlast)
                    state <= FLUSH;
                end
        FLUSH:
          if (slot_free)
            begin
              window_o.tvalid <= 1'b1;
              window_o.tlast  <= 1'b1;
              window_o.tuser  <= 1'b0;
              state           <= RUN;
            end
        default:
          state <= IDLE;
      endcase
    end

endmodule

`default_nettype wire

//--- verilog/bilinear_demosaic_3x3.sv
`default_nettype none

module bilinear_demosaic_3x3 (
  input wire             clk_i,
  input wire             rst_i,
  input wire             en_i,
  input wire             first_px_is_odd_i,
  input wire             first_line_is_odd_i,
  video_stream_if.slave  win_i,
  video_stream_if.master rgb_o
);

localparam int PW = $bits(demosaic_pkg::raw_px_t);

demosaic_pkg::win3_t        win;
demosaic_pkg::bayer_phase_e phase;
logic                       adv;
logic                       win_acc;
logic                       cur_odd_px;
logic                       cur_odd_line;
logic                       odd_px_q;
logic                       odd_line_q;

logic [PW:0]                cross_half0_s1;
logic [PW:0]                cross_half1_s1;
logic [PW:0]                diag_half0_s1;
logic [PW:0]                diag_half1_s1;
logic [PW:0]                lr_sum_s1;
logic [PW:0]                ud_sum_s1;
demosaic_pkg::raw_px_t      centre_s1;
demosaic_pkg::bayer_phase_e phase_s1;
logic                       valid_s1;
logic                       last_s1;
logic                       user_s1;

logic [PW + 1:0]            cross_sum_s2;
logic [PW + 1:0]            diag_sum_s2;
demosaic_pkg::raw_px_t      lr_avg_s2;
demosaic_pkg::raw_px_t      ud_avg_s2;
demosaic_pkg::raw_px_t      centre_s2;
demosaic_pkg::bayer_phase_e phase_s2;
logic                       valid_s2;
logic                       last_s2;
logic                       user_s2;

demosaic_pkg::raw_px_t      cross_avg;
demosaic_pkg::raw_px_t      diag_avg;
demosaic_pkg::rgb_px_t      rgb_d;

assign win           = win_i.tdata;
assign adv           = !rgb_o.tvalid || rgb_o.tready;   // All stages move together.
assign win_i.tready  = adv;
assign win_acc       = win_i.tvalid && adv;

// ====================
// Bayer phase
// ====================

assign cur_odd_px   = win_i.tuser ? first_px_is_odd_i : odd_px_q;
assign cur_odd_line = win_i.tuser ? first_line_is_odd_i : odd_line_q;
assign phase        = demosaic_pkg::bayer_phase_e'({cur_odd_line, cur_odd_px});

always_ff @(posedge clk_i, posedge rst_i)
  if (rst_i)
    begin
      odd_px_q   <= 1'b0;
      odd_line_q <= 1'b0;
    end
  else
    if (win_acc)
      begin
        odd_px_q   <= win_i.tlast ? first_px_is_odd_i : !cur_odd_px;
        odd_line_q <= win_i.tlast ? !cur_odd_line : cur_odd_line;
      end

// ====================
// Datapath
// ====================

always_ff @(posedge clk_i)
  if (adv)
    begin
      cross_half0_s1 <= {1'b0, win[1][0]} + {1'b0, win[0][1]};
      cross_half1_s1 <= {1'b0, win[1][2]} + {1'b0, win[2][1]};
      diag_half0_s1  <= {1'b0, win[0][0]} + {1'b0, win[0][2]};
      diag_half1_s1  <= {1'b0, win[2][0]} + {1'b0, win[2][2]};
      lr_sum_s1      <= {1'b0, win[1][0]} + {1'b0, win[1][2]};
      ud_sum_s1      <= {1'b0, win[0][1]} + {1'b0, win[2][1]};
      centre_s1      <= win[1][1];
      phase_s1       <= phase;

      cross_sum_s2   <= {1'b0, cross_half0_s1} + {1'b0, cross_half1_s1};
      diag_sum_s2    <= {1'b0, diag_half0_s1} + {1'b0, diag_half1_s1};
      lr_avg_s2      <= lr_sum_s1[PW:1];
      ud_avg_s2      <= ud_sum_s1[PW:1];
      centre_s2      <= centre_s1;
      phase_s2       <= phase_s1;

      rgb_o.tdata    <= rgb_d;
    end

assign cross_avg = cross_sum_s2[PW + 1:2];
assign diag_avg  = diag_sum_s2[PW + 1:2];

// Missing colours per site. With interpolation off the raw value fills every channel.
always_comb
  begin
    rgb_d.r = centre_s2;
    rgb_d.g = centre_s2;
    rgb_d.b = centre_s2;
    if (en_i)
      case (phase_s2)
        demosaic_pkg::PH_R:
          begin
            rgb_d.g = cross_avg;
            rgb_d.b = diag_avg;
          end
        demosaic_pkg::PH_GR:
          begin
            rgb_d.r = lr_avg_s2;
            rgb_d.b = ud_avg_s2;
          end
        demosaic_pkg::PH_GB:
          begin
            rgb_d.b = lr_avg_s2;
            rgb_d.r = ud_avg_s2;
          end
        demosaic_pkg::PH_B:
          begin
            rgb_d.g = cross_avg;
            rgb_d.r = diag_avg;
          end
      endcase
  end

// ====================
// Valid and framing
// ====================

always_ff @(posedge clk_i, posedge rst_i)
  if (rst_i)
    begin
      valid_s1     <= 1'b0;
      last_s1      <= 1'b0;
      user_s1      <= 1'b0;
      valid_s2     <= 1'b0;
      last_s2      <= 1'b0;
      user_s2      <= 1'b0;
      rgb_o.tvalid <= 1'b0;
      rgb_o.tlast  <= 1'b0;
      rgb_o.tuser  <= 1'b0;
    end
  else
    if (adv)
      begin
        valid_s1     <= win_i.tvalid;
        last_s1      <= win_i.tvalid && win_i.tlast;   // Bubbles carry no framing flags.
        user_s1      <= win_i.tvalid && win_i.tuser;
        valid_s2     <= valid_s1;
        last_s2      <= last_s1;
        user_s2      <= user_s1;
        rgb_o.tvalid <= valid_s2;
        rgb_o.tlast  <= last_s2;
        rgb_o.tuser  <= user_s2;
      end

endmodule

`default_nettype wire

//--- verilog/demosaic_top.sv
`default_nettype none
`include "demosaic_cfg.svh"

module demosaic_top (
  input  wire                                clk_i,
  input  wire                                rst_i,
  input  wire  [`DM_RAW_PX_WIDTH - 1:0]      raw_tdata_i,
  input  wire                                raw_tvalid_i,
  input  wire                                raw_tlast_i,
  input  wire                                raw_tuser_i,
  output logic                               raw_tready_o,
  input  wire                                en_i,
  input  wire                                first_px_is_odd_i,
  input  wire                                first_line_is_odd_i,
  output logic [3 * `DM_RAW_PX_WIDTH - 1:0]  rgb_tdata_o,
  output logic                               rgb_tvalid_o,
  output logic                               rgb_tlast_o,
  output logic                               rgb_tuser_o,
  input  wire                                rgb_tready_i
);

localparam int RAW_W = `DM_RAW_PX_WIDTH;
localparam int WIN_W = 9 * RAW_W;
localparam int RGB_W = 3 * RAW_W;

video_stream_if #(.WIDTH(RAW_W)) raw_stream ();
video_stream_if #(.WIDTH(WIN_W)) win_stream ();
video_stream_if #(.WIDTH(RGB_W)) rgb_stream ();

assign raw_stream.tdata  = raw_tdata_i;
assign raw_stream.tvalid = raw_tvalid_i;
assign raw_stream.tlast  = raw_tlast_i;
assign raw_stream.tuser  = raw_tuser_i;
assign raw_tready_o      = raw_stream.tready;

assign rgb_tdata_o       = rgb_stream.tdata;
assign rgb_tvalid_o      = rgb_stream.tvalid;
assign rgb_tlast_o       = rgb_stream.tlast;
assign rgb_tuser_o       = rgb_stream.tuser;
assign rgb_stream.tready = rgb_tready_i;

window_buf #(
  .PX_WIDTH      ( RAW_W             ),
  .MAX_LINE_SIZE ( `DM_MAX_LINE_SIZE )
) window_buf_inst (
  .clk_i         ( clk_i             ),
  .rst_i         ( rst_i             ),
  .video_i       ( raw_stream        ),
  .window_o      ( win_stream        )
);

bilinear_demosaic_3x3 bilinear_inst (
  .clk_i               ( clk_i               ),
  .rst_i               ( rst_i               ),
  .en_i                ( en_i                ),
  .first_px_is_odd_i   ( first_px_is_odd_i   ),
  .first_line_is_odd_i ( first_line_is_odd_i ),
  .win_i               ( win_stream          ),
  .rgb_o               ( rgb_stream          )
);

endmodule

`default_nettype wire

//--- bench/tb_ref_model.svh
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// ====================
// Frames and random source
// ====================

localparam int          FRAME_W  = 8;
localparam int          FRAME_H  = 6;
localparam int          OUT_H    = FRAME_H - 2;   // Only interior rows come out.
localparam logic [31:0] LCG_SEED = 32'hbaac_f3a8;

demosaic_pkg::raw_px_t raw_frame [2][FRAME_H][FRAME_W];
logic [31:0]           rand_state = LCG_SEED;

function automatic logic [31:0] lcg_step(input logic [31:0] s);
  return s * 32'd1664525 + 32'd1013904223;
endfunction

function automatic logic [31:0] next_rand_word();
  rand_state = lcg_step(rand_state);
  return rand_state;
endfunction

task automatic fill_const(input int f, input demosaic_pkg::raw_px_t value);
  for (int y = 0; y < FRAME_H; y++)
    for (int x = 0; x < FRAME_W; x++)
      raw_frame[f][y][x] = value;
endtask

task automatic fill_random(input int f);
  logic [31:0] word;
  for (int y = 0; y < FRAME_H; y++)
    for (int x = 0; x < FRAME_W; x++)
      begin
        word               = next_rand_word();
        raw_frame[f][y][x] = word[31:32 - `DM_RAW_PX_WIDTH];   // High LCG bits vary the most.
      end
endtask

// ====================
// Reference model
// ====================

// Raw pixel with the left and right line edges replicated.
function automatic int src_px(input int f, input int y, input int x);
  int xc;
  xc = (x < 0) ? 0 : ((x > FRAME_W - 1) ? FRAME_W - 1 : x);
  return int'(raw_frame[f][y][xc]);
endfunction

function automatic demosaic_pkg::raw_px_t to_px(input int v);
  return demosaic_pkg::raw_px_t'(v);
endfunction

function automatic demosaic_pkg::rgb_px_t model_rgb(input int f, input int oy, input int x,
                                                    input logic en, input logic px_odd,
                                                    input logic line_odd);
  int                         y;
  int                         centre;
  int                         cross_avg;
  int                         diag_avg;
  int                         lr_avg;
  int                         ud_avg;
  demosaic_pkg::bayer_phase_e site;
  demosaic_pkg::rgb_px_t      px;
  y         = oy + 1;                                  // Output row 0 sits on input row 1.
  centre    = src_px(f, y, x);
  cross_avg = (src_px(f, y, x - 1) + src_px(f, y, x + 1) +
               src_px(f, y - 1, x) + src_px(f, y + 1, x)) / 4;
  diag_avg  = (src_px(f, y - 1, x - 1) + src_px(f, y - 1, x + 1) +
               src_px(f, y + 1, x - 1) + src_px(f, y + 1, x + 1)) / 4;
  lr_avg    = (src_px(f, y, x - 1) + src_px(f, y, x + 1)) / 2;
  ud_avg    = (src_px(f, y - 1, x) + src_px(f, y + 1, x)) / 2;
  site      = demosaic_pkg::bayer_phase_e'({line_odd ^ 1'(oy % 2), px_odd ^ 1'(x % 2)});
  px.r      = to_px(centre);
  px.g      = to_px(centre);
  px.b      = to_px(centre);
  if (en)
    case (site)
      demosaic_pkg::PH_R:
        begin
          px.g = to_px(cross_avg);
          px.b = to_px(diag_avg);
        end
      demosaic_pkg::PH_GR:
        begin
          px.r = to_px(lr_avg);
          px.b = to_px(ud_avg);
        end
      demosaic_pkg::PH_GB:
        begin
          px.b = to_px(lr_avg);
          px.r = to_px(ud_avg);
        end
      demosaic_pkg::PH_B:
        begin
          px.g = to_px(cross_avg);
          px.r = to_px(diag_avg);
        end
    endcase
  return px;
endfunction

`endif

//--- bench/tb_demosaic.sv
`default_nettype none
`include "demosaic_cfg.svh"

module tb_demosaic;

timeunit 1ns;
timeprecision 1ps;

localparam int PX_W         = `DM_RAW_PX_WIDTH;
localparam int RGB_W        = 3 * PX_W;
localparam int CLK_PERIOD   = 20;
localparam int TOTAL_FRAMES = 9;   // Frames sent over all tests together.

logic               clk_i;
logic               rst_i;
logic [PX_W - 1:0]  raw_tdata_i;
logic               raw_tvalid_i;
logic               raw_tlast_i;
logic               raw_tuser_i;
logic               raw_tready_o;
logic               en_i;
logic               first_px_is_odd_i;
logic               first_line_is_odd_i;
logic [RGB_W - 1:0] rgb_tdata_o;
logic               rgb_tvalid_o;
logic               rgb_tlast_o;
logic               rgb_tuser_o;
logic               rgb_tready_i;

logic [RGB_W - 1:0] got_data [$];
logic               got_last [$];
logic               got_user [$];
logic               bp_on = 1'b0;
logic [31:0]        ready_state;
int                 error_count = 0;
int                 check_count = 0;

`include "tb_ref_model.svh"

localparam int WATCHDOG_NS = 20 * TOTAL_FRAMES * FRAME_W * FRAME_H * CLK_PERIOD;

demosaic_top dut0 (
  .clk_i               ( clk_i               ),
  .rst_i               ( rst_i               ),
  .raw_tdata_i         ( raw_tdata_i         ),
  .raw_tvalid_i        ( raw_tvalid_i        ),
  .raw_tlast_i         ( raw_tlast_i         ),
  .raw_tuser_i         ( raw_tuser_i         ),
  .raw_tready_o        ( raw_tready_o        ),
  .en_i                ( en_i                ),
  .first_px_is_odd_i   ( first_px_is_odd_i   ),
  .first_line_is_odd_i ( first_line_is_odd_i ),
  .rgb_tdata_o         ( rgb_tdata_o         ),
  .rgb_tvalid_o        ( rgb_tvalid_o        ),
  .rgb_tlast_o         ( rgb_tlast_o         ),
  .rgb_tuser_o         ( rgb_tuser_o         ),
  .rgb_tready_i        ( rgb_tready_i        )
);

// ====================
// Clock, sink and watchdog
// ====================

initial
  begin
    clk_i = 1'b0;
    forever
      #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

// Output ready follows the LCG while back-pressure is on.
initial
  begin
    rgb_tready_i = 1'b1;
    ready_state  = LCG_SEED;
    forever
      begin
        @(posedge clk_i);
        ready_state  = lcg_step(ready_state);
        rgb_tready_i <= bp_on ? ready_state[31] : 1'b1;
      end
  end

initial
  forever
    begin
      @(posedge clk_i);
      if (!rst_i && rgb_tvalid_o && rgb_tready_i)
        begin
          got_data.push_back(rgb_tdata_o);
          got_last.push_back(rgb_tlast_o);
          got_user.push_back(rgb_tuser_o);
        end
    end

initial
  begin
    #(WATCHDOG_NS);
    $display("Timeout: the tests did not finish within %0d ns.", WATCHDOG_NS);
    $display("Verification failed");
    $finish;
  end

// ====================
// Driver and checks
// ====================

task automatic check_equal(input logic [31:0] got, input logic [31:0] exp, input string what);
  check_count++;
  if (got !== exp)
    begin
      error_count++;
      $display("MISMATCH at %0t: %s, got 0x%h, expected 0x%h", $time, what, got, exp);
    end
endtask

task automatic send_pixel(input demosaic_pkg::raw_px_t px, input logic last, input logic first,
                          input logic gaps);
  logic [31:0] roll;
  roll = next_rand_word();
  while (gaps && (roll[31:30] == 2'b00))
    begin
      raw_tvalid_i <= 1'b0;                  // Idle beat on the input.
      @(posedge clk_i);
      roll = next_rand_word();
    end
  raw_tdata_i  <= px;
  raw_tvalid_i <= 1'b1;
  raw_tlast_i  <= last;
  raw_tuser_i  <= first;
  @(posedge clk_i);
  while (!raw_tready_o)
    @(posedge clk_i);
endtask

task automatic run_frames(input int n_frames, input logic en, input logic px_odd,
                          input logic line_odd, input logic stall);
  int n_exp;
  n_exp = n_frames * FRAME_W * OUT_H;
  got_data.delete();
  got_last.delete();
  got_user.delete();
  en_i                <= en;
  first_px_is_odd_i   <= px_odd;
  first_line_is_odd_i <= line_odd;
  bp_on               <= stall;
  @(posedge clk_i);
  for (int f = 0; f < n_frames; f++)
    begin
      // The first line parity flips per frame, so only a phase restart on tuser follows it.
      first_line_is_odd_i <= line_odd ^ 1'(f % 2);
      for (int y = 0; y < FRAME_H; y++)
        for (int x = 0; x < FRAME_W; x++)
          send_pixel(raw_frame[f][y][x], x == FRAME_W - 1, (y == 0) && (x == 0), stall);
    end
  raw_tvalid_i <= 1'b0;
  raw_tlast_i  <= 1'b0;
  raw_tuser_i  <= 1'b0;
  while (got_data.size() < n_exp)
    @(posedge clk_i);
  bp_on <= 1'b0;
  repeat (8)
    @(posedge clk_i);                        // A surplus beat would be caught here.
endtask

task automatic compare_frames(input int n_frames, input logic en, input logic px_odd,
                              input logic line_odd, input string name);
  int idx;
  check_equal(32'(got_data.size()), 32'(n_frames * FRAME_W * OUT_H),
              $sformatf("%s output pixel count", name));
  idx = 0;
  for (int f = 0; f < n_frames; f++)
    for (int oy = 0; oy < OUT_H; oy++)
      for (int x = 0; x < FRAME_W; x++)
        begin
          check_equal(32'(got_data[idx]),
                      32'(model_rgb(f, oy, x, en, px_odd, line_odd ^ 1'(f % 2))),
                      $sformatf("%s frame %0d row %0d col %0d rgb", name, f, oy, x));
          check_equal(32'(got_user[idx]), 32'((oy == 0) && (x == 0)),
                      $sformatf("%s frame %0d row %0d col %0d tuser", name, f, oy, x));
          check_equal(32'(got_last[idx]), 32'(x == FRAME_W - 1),
                      $sformatf("%s frame %0d row %0d col %0d tlast", name, f, oy, x));
          idx++;
        end
endtask

// ====================
// Tests
// ====================

task automatic test_flat_field();
  demosaic_pkg::raw_px_t level;
  level = demosaic_pkg::raw_px_t'(677);
  fill_const(0, level);
  run_frames(1, 1'b1, 1'b0, 1'b0, 1'b0);
  compare_frames(1, 1'b1, 1'b0, 1'b0, "flat field");
  for (int i = 0; i < got_data.size(); i++)
    check_equal(32'(got_data[i]), 32'({level, level, level}),
                $sformatf("flat field pixel %0d", i));
endtask

task automatic test_bypass();
  fill_random(0);
  run_frames(1, 1'b0, 1'b1, 1'b0, 1'b0);
  compare_frames(1, 1'b0, 1'b1, 1'b0, "bypass");
endtask

task automatic test_phases();
  fill_random(0);
  for (int s = 0; s < 4; s++)
    begin
      run_frames(1, 1'b1, 1'(s % 2), 1'(s / 2), 1'b0);
      compare_frames(1, 1'b1, 1'(s % 2), 1'(s / 2), $sformatf("phase setting %0d", s));
    end
endtask

task automatic test_back_pressure();
  fill_random(0);
  run_frames(1, 1'b1, 1'b0, 1'b1, 1'b1);
  compare_frames(1, 1'b1, 1'b0, 1'b1, "back-pressure");
endtask

task automatic test_back_to_back();
  int user_cnt;
  int last_cnt;
  fill_random(0);
  fill_random(1);
  run_frames(2, 1'b1, 1'b1, 1'b1, 1'b0);
  compare_frames(2, 1'b1, 1'b1, 1'b1, "back-to-back");
  user_cnt = 0;
  last_cnt = 0;
  for (int i = 0; i < got_data.size(); i++)
    begin
      user_cnt += int'(got_user[i]);
      last_cnt += int'(got_last[i]);
    end
  check_equal(32'(user_cnt), 32'(2), "back-to-back tuser beats");
  check_equal(32'(last_cnt), 32'(2 * OUT_H), "back-to-back tlast beats");
endtask

// ====================
// Main sequence
// ====================

initial
  begin
    rst_i               = 1'b1;
    raw_tdata_i         = '0;
    raw_tvalid_i        = 1'b0;
    raw_tlast_i         = 1'b0;
    raw_tuser_i         = 1'b0;
    en_i                = 1'b1;
    first_px_is_odd_i   = 1'b0;
    first_line_is_odd_i = 1'b0;
    repeat (5)
      @(posedge clk_i);
    rst_i <= 1'b0;
    @(posedge clk_i);
    test_flat_field();
    test_bypass();
    test_phases();
    test_back_pressure();
    test_back_to_back();
    $display("Checks run: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0)
      $display("Verification passed");
    else
      $display("Verification failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- files.f
+incdir+verilog
+incdir+bench
verilog/demosaic_pkg.sv
verilog/video_stream_if.sv
verilog/line_buffer.sv
verilog/window_buf.sv
verilog/bilinear_demosaic_3x3.sv
verilog/demosaic_top.sv
bench/tb_demosaic.sv

//--- run.sh
#!/bin/sh
# Builds the demosaic testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -j 0 --top-module tb_demosaic -f files.f
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

output=$(./obj_dir/Vtb_demosaic)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -q "^Verification passed$"; then
  exit 0
fi
exit 1
